//--- build.f
src/sd_dma_pkg.sv
src/sd_dma_regs.sv
src/sd_dma_fifo.sv
src/sd_spi_seq.sv
src/sd_dma_seq.sv
src/sd_dma_top.sv
verification/tb_sd_dma.sv

//--- Bender.yml
package:
  name: sd_dma

sources:
  - src/sd_dma_pkg.sv
  - src/sd_dma_regs.sv
  - src/sd_dma_fifo.sv
  - src/sd_spi_seq.sv
  - src/sd_dma_seq.sv
  - src/sd_dma_top.sv
  - target: simulation
    files:
      - verification/tb_sd_dma.sv

//--- verification/tb_sd_dma.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sd_dma;

	localparam int n_xfers        = 4;
	localparam int timeout_cycles = n_xfers * sd_dma_pkg::block_len * 24 + 2000;
	localparam int ph_idle        = 0; // memory model phases
	localparam int ph_wait_ack    = 1;
	localparam int ph_wait_end    = 2;
	localparam int ph_ack         = 3;
	localparam int ph_end         = 4;

	logic                              clk = 1'b0;
	logic                              rst_n;
	sd_dma_pkg::reg_bus_t              bus;
	logic [sd_dma_pkg::data_w-1:0]     dout;
	logic                              sd_rdy = 1'b1;          // card idle and ready
	logic [sd_dma_pkg::data_w-1:0]     sd_receiveddata = 8'h00;
	sd_dma_pkg::spi_ctl_t              spi;
	logic [sd_dma_pkg::addr_w-1:0]     dma_addr;
	sd_dma_pkg::dma_bus_t              dma;
	logic [sd_dma_pkg::data_w-1:0]     dma_rd = 8'h00;
	logic                              dma_ack = 1'b0;
	logic                              dma_end = 1'b0;

	logic [7:0]  mem_model [logic [sd_dma_pkg::addr_w-1:0]]; // sparse memory
	logic [7:0]  card_rx [$];      // bytes the card handed over
	logic [7:0]  card_tx [$];      // datatosend per exchange
	logic        cur_snr = 1'b0;   // direction of running transfer
	logic        card_start = 1'b0;
	int          card_cnt = 0;     // cycles until sd_rdy returns
	int          mem_phase = ph_idle;
	int          mem_cnt = 0;
	logic        mem_ack_nx;
	logic        mem_end_nx;
	logic [7:0]  mem_rd_nx = 8'h00;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int unsigned rng_init;

	always #20 clk = ~clk; // 40 ns period

	sd_dma_top u_dut
	(
		.clk(clk), .rst_n(rst_n), .bus(bus), .dout(dout), .sd_rdy(sd_rdy),
		.sd_receiveddata(sd_receiveddata), .spi(spi), .dma_addr(dma_addr), .dma(dma),
		.dma_rd(dma_rd), .dma_ack(dma_ack), .dma_end(dma_end)
	);

	////////////////////////////////////////////////////////////
	// helpers

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [7:0] mem_byte(input logic [sd_dma_pkg::addr_w-1:0] a);
		if (!mem_model.exists(a))
			mem_model[a] = 8'($urandom); // fresh random content
		return mem_model[a];
	endfunction

	task automatic reg_write(input logic [1:0] sel, input logic [7:0] data);
		bus.sel    = 1'b1;
		bus.wr     = 1'b1;
		bus.regsel = sel;
		bus.din    = data;
		@(posedge clk);
		#2;
		bus.sel = 1'b0;
		bus.wr  = 1'b0;
	endtask

	task automatic reg_read(input logic [1:0] sel, output logic [7:0] data);
		bus.sel    = 1'b1;
		bus.wr     = 1'b0;
		bus.regsel = sel;
		@(negedge clk);
		data = dout;
		if (sel == sd_dma_pkg::reg_cst && !dout[sd_dma_pkg::cst_on_bit])
			check_val("spi.override", spi.override, 1'b0); // engine stopped, spi released
		@(posedge clk);
		#2;
		bus.sel = 1'b0;
	endtask

	task automatic write_addr(input logic [sd_dma_pkg::addr_w-1:0] a);
		reg_write(sd_dma_pkg::reg_had, {2'b00, a[21:16]});
		reg_write(sd_dma_pkg::reg_mad, a[15:8]);
		reg_write(sd_dma_pkg::reg_lad, a[7:0]);
	endtask

	task automatic check_addr(input string tag, input logic [sd_dma_pkg::addr_w-1:0] e);
		logic [7:0] v;
		reg_read(sd_dma_pkg::reg_had, v);
		check_val({tag, " had"}, v, {2'b00, e[21:16]});
		reg_read(sd_dma_pkg::reg_mad, v);
		check_val({tag, " mad"}, v, e[15:8]);
		reg_read(sd_dma_pkg::reg_lad, v);
		check_val({tag, " lad"}, v, e[7:0]);
	endtask

	////////////////////////////////////////////////////////////
	// tests

	task automatic test_registers();
		logic [7:0] h;
		logic [7:0] m;
		logic [7:0] l;
		logic [7:0] c;
		logic [7:0] v;
		repeat (8)
		begin
			h = 8'($urandom); // top two bits must drop out
			m = 8'($urandom);
			l = 8'($urandom);
			reg_write(sd_dma_pkg::reg_had, h);
			reg_write(sd_dma_pkg::reg_mad, m);
			reg_write(sd_dma_pkg::reg_lad, l);
			check_addr("readback", {h[5:0], m, l});
			c = 8'($urandom) & 8'h7f; // bit 7 clear, engine stays off
			reg_write(sd_dma_pkg::reg_cst, c);
			reg_read(sd_dma_pkg::reg_cst, v);
			check_val("cst readback", v, {7'b0, c[sd_dma_pkg::cst_snr_bit]});
		end
	endtask

	task automatic run_transfer(input logic snr);
		logic [sd_dma_pkg::addr_w-1:0] a;
		logic [sd_dma_pkg::addr_w-1:0] key;
		logic [7:0]                    v;
		a = 22'($urandom);
		write_addr(a);
		card_rx.delete();
		card_tx.delete();
		cur_snr = snr;
		reg_write(sd_dma_pkg::reg_cst, {1'b1, 6'b0, snr}); // go
		reg_read(sd_dma_pkg::reg_cst, v);
		check_val("cst after start", v, {1'b1, 6'b0, snr});
		do
			reg_read(sd_dma_pkg::reg_cst, v); // poll busy bit
		while (v[sd_dma_pkg::cst_on_bit]);
		check_val("cst after finish", v, {7'b0, snr});
		check_addr("end", a + 22'd512);
		if (!snr && card_rx.size() != sd_dma_pkg::block_len)
		begin
			errors++;
			$display("receive transfer took %0d card bytes instead of 512", card_rx.size());
		end
		else if (snr && card_tx.size() != sd_dma_pkg::block_len)
		begin
			errors++;
			$display("send transfer gave the card %0d bytes instead of 512", card_tx.size());
		end
		else
		begin
			for (int i = 0; i < sd_dma_pkg::block_len; i++)
			begin
				key = a + 22'(i);
				if (!mem_model.exists(key))
				begin
					errors++;
					$display("memory byte at %h was never touched by the transfer", key);
				end
				else if (!snr)
					check_val($sformatf("mem[%h]", key), mem_model[key], card_rx[i]);
				else
					check_val($sformatf("datatosend %0d", i), card_tx[i], mem_model[key]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// sd card model

	always
	begin
		@(negedge clk);
		card_start = rst_n && spi.start;
		if (card_start)
		begin
			if (!sd_rdy)
			begin
				errors++;
				$display("spi start issued at %0t while sd_rdy was low", $time);
			end
			card_tx.push_back(spi.datatosend);
			if (!cur_snr)
				check_val("spi.datatosend", spi.datatosend, 8'hFF); // dummy byte on receive
		end
		@(posedge clk);
		#2;
		if (card_start)
		begin
			sd_rdy   = 1'b0;              // shifting
			card_cnt = 1 + $urandom % 8;
		end
		else if (card_cnt > 0)
		begin
			card_cnt--;
			if (card_cnt == 0)
			begin
				sd_rdy          = 1'b1;
				sd_receiveddata = 8'($urandom);
				card_rx.push_back(sd_receiveddata);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// memory model

	always
	begin
		@(negedge clk);
		mem_ack_nx = 1'b0;
		mem_end_nx = 1'b0;
		if (dma_end)
			mem_phase = ph_idle;
		if (dma_ack)
		begin
			if (dma.rnw)
				mem_rd_nx = mem_byte(dma_addr);
			else
				mem_model[dma_addr] = dma.wd; // address latched at ack
			mem_phase = ph_wait_end;
			mem_cnt   = $urandom % 3;
		end
		if (mem_phase == ph_idle && rst_n && dma.req)
		begin
			mem_phase = ph_wait_ack;
			mem_cnt   = $urandom % 5;
		end
		if (mem_phase == ph_wait_ack)
		begin
			if (mem_cnt == 0)
			begin
				mem_ack_nx = 1'b1;
				mem_phase  = ph_ack;
			end
			else
				mem_cnt--;
		end
		if (mem_phase == ph_wait_end)
		begin
			if (mem_cnt == 0)
			begin
				mem_end_nx = 1'b1;
				mem_phase  = ph_end;
			end
			else
				mem_cnt--;
		end
		@(posedge clk);
		#2;
		dma_ack = mem_ack_nx;
		dma_end = mem_end_nx;
		if (mem_end_nx)
			dma_rd = mem_rd_nx; // read data valid at end
	end

	////////////////////////////////////////////////////////////
	// run control

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= timeout_cycles)
		begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Checks failed");
			$finish;
		end
	end

	initial
	begin
		rng_init = $urandom(32'hdf2fb61c);
		rst_n    = 1'b0;
		bus      = '0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_registers();
		for (int t = 0; t < n_xfers; t++)
			run_transfer(t[0]); // receive and send in turn
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/sd_dma_top.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dma_top
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire sd_dma_pkg::reg_bus_t         bus,
	output logic [sd_dma_pkg::data_w-1:0]     dout,
	input  wire                               sd_rdy,
	input  wire [sd_dma_pkg::data_w-1:0]      sd_receiveddata,
	output sd_dma_pkg::spi_ctl_t              spi,
	output logic [sd_dma_pkg::addr_w-1:0]     dma_addr,
	output sd_dma_pkg::dma_bus_t              dma,
	input  wire [sd_dma_pkg::data_w-1:0]      dma_rd,
	input  wire                               dma_ack,
	input  wire                               dma_end
);
	logic                          snr;         // direction level
	logic                          start_pulse; // kicks fifo and both sides
	logic                          sd_busy;
	logic                          dma_busy;
	sd_dma_pkg::fifo_wr_t          sd_wr;       // card -> fifo
	sd_dma_pkg::fifo_wr_t          dma_wr;      // memory -> fifo
	logic                          sd_rd_stb;
	logic                          dma_rd_stb;
	sd_dma_pkg::fifo_stat_t        stat;
	logic [sd_dma_pkg::data_w-1:0] fifo_rd;

	sd_dma_regs u_regs (.clk, .rst_n, .bus, .dma_ack, .sd_busy, .dma_busy, .dout, .dma_addr,
		.dma_on(), .snr, .start_pulse);

	sd_dma_fifo u_fifo (.clk, .rst_n, .init(start_pulse), .sd_wr, .dma_wr, .sd_rd_stb,
		.dma_rd_stb, .stat, .rd(fifo_rd));

	sd_spi_seq u_spi_seq (.clk, .rst_n, .start_pulse, .snr, .sd_rdy, .sd_receiveddata, .stat,
		.fifo_rd, .spi, .sd_wr, .rd_stb(sd_rd_stb), .busy(sd_busy));

	sd_dma_seq u_dma_seq (.clk, .rst_n, .start_pulse, .snr, .dma_ack, .dma_end, .dma_rd, .stat,
		.fifo_rd, .dma, .dma_wr, .rd_stb(dma_rd_stb), .busy(dma_busy));

endmodule

`default_nettype wire

//--- src/sd_dma_seq.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dma_seq
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               start_pulse,
	input  wire                               snr,
	input  wire                               dma_ack,
	input  wire                               dma_end,
	input  wire [sd_dma_pkg::data_w-1:0]      dma_rd,
	input  wire sd_dma_pkg::fifo_stat_t       stat,
	input  wire [sd_dma_pkg::data_w-1:0]      fifo_rd,
	output sd_dma_pkg::dma_bus_t              dma,
	output sd_dma_pkg::fifo_wr_t              dma_wr,
	output logic                              rd_stb,
	output logic                              busy
);
	sd_dma_pkg::dma_state_t state;
	sd_dma_pkg::dma_state_t next_state;
	logic                   put_go;  // byte ready for memory
	logic                   get_go;  // room left for another byte
	logic                   get_on;  // memory read phase

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= sd_dma_pkg::dma_idle;
		else
			state <= next_state;
	end

	assign put_go = (state == sd_dma_pkg::dma_put_req) && !stat.rdone && !stat.empty;
	assign get_go = (state == sd_dma_pkg::dma_get_req) && !stat.wdone;
	assign get_on = (state == sd_dma_pkg::dma_get_req) || (state == sd_dma_pkg::dma_get_end);

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		next_state = state;
		case (state)
			sd_dma_pkg::dma_idle:
				if (start_pulse)
					next_state = snr ? sd_dma_pkg::dma_get_req : sd_dma_pkg::dma_put_req;
			sd_dma_pkg::dma_put_req:
				if (stat.rdone)
					next_state = sd_dma_pkg::dma_idle; // block stored
				else if (put_go && dma_ack)
					next_state = sd_dma_pkg::dma_put_end;
			sd_dma_pkg::dma_put_end:
				if (dma_end)
					next_state = sd_dma_pkg::dma_put_req;
			sd_dma_pkg::dma_get_req:
				if (stat.wdone)
					next_state = sd_dma_pkg::dma_idle; // block fetched
				else if (dma_ack)
					next_state = sd_dma_pkg::dma_get_end;
			sd_dma_pkg::dma_get_end:
				if (dma_end)
					next_state = sd_dma_pkg::dma_get_req;
			default:
				next_state = sd_dma_pkg::dma_idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// outputs

	always_comb
	begin
		busy        = (state != sd_dma_pkg::dma_idle);
		dma.req     = put_go || get_go; // stays up until ack
		dma.rnw     = get_on;
		dma.wd      = fifo_rd;          // stable until the pop at ack
		rd_stb      = put_go && dma_ack;
		dma_wr.stb  = (state == sd_dma_pkg::dma_get_end) && dma_end;
		dma_wr.data = dma_rd;           // read data valid at end
	end

	// memory side must not answer an absent request
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) dma_ack |-> dma.req);

endmodule

`default_nettype wire

//--- src/sd_spi_seq.sv
`timescale 1ns/100ps
`default_nettype none

module sd_spi_seq
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               start_pulse,
	input  wire                               snr,
	input  wire                               sd_rdy,
	input  wire [sd_dma_pkg::data_w-1:0]      sd_receiveddata,
	input  wire sd_dma_pkg::fifo_stat_t       stat,
	input  wire [sd_dma_pkg::data_w-1:0]      fifo_rd,
	output sd_dma_pkg::spi_ctl_t              spi,
	output sd_dma_pkg::fifo_wr_t              sd_wr,
	output logic                              rd_stb,
	output logic                              busy
);
	sd_dma_pkg::sd_state_t state;
	sd_dma_pkg::sd_state_t next_state;
	logic                  rx_go; // fire a dummy read exchange
	logic                  tx_go; // fire a send exchange

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= sd_dma_pkg::sd_idle;
		else
			state <= next_state;
	end

	assign rx_go = (state == sd_dma_pkg::sd_rx_start) && !stat.wdone && sd_rdy;
	assign tx_go = (state == sd_dma_pkg::sd_tx_wait) && !stat.rdone && !stat.empty && sd_rdy;

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		next_state = state;
		case (state)
			sd_dma_pkg::sd_idle:
				if (start_pulse)
					next_state = snr ? sd_dma_pkg::sd_tx_wait : sd_dma_pkg::sd_rx_start;
			sd_dma_pkg::sd_rx_start:
				if (stat.wdone)
					next_state = sd_dma_pkg::sd_idle; // whole block received
				else if (rx_go)
					next_state = sd_dma_pkg::sd_rx_wait;
			sd_dma_pkg::sd_rx_wait:
				if (sd_rdy)
					next_state = sd_dma_pkg::sd_rx_start; // byte pushed this cycle
			sd_dma_pkg::sd_tx_wait:
				if (stat.rdone && sd_rdy)
					next_state = sd_dma_pkg::sd_idle; // last byte fully shifted
			default:
				next_state = sd_dma_pkg::sd_idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// outputs

	always_comb
	begin
		busy              = (state != sd_dma_pkg::sd_idle);
		spi.start         = rx_go || tx_go;
		spi.override      = busy; // hold the spi for the whole block
		spi.datatosend    = (state == sd_dma_pkg::sd_tx_wait) ? fifo_rd : 8'hFF;
		sd_wr.stb         = (state == sd_dma_pkg::sd_rx_wait) && sd_rdy;
		sd_wr.data        = sd_receiveddata;
		rd_stb            = tx_go; // pop together with start
	end

	// card takes the exchange and drops ready
	a_start_rdy: assert property (@(posedge clk) disable iff (!rst_n) spi.start |=> !sd_rdy);

endmodule

`default_nettype wire

//--- src/sd_dma_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dma_fifo
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               init,
	input  wire sd_dma_pkg::fifo_wr_t         sd_wr,
	input  wire sd_dma_pkg::fifo_wr_t         dma_wr,
	input  wire                               sd_rd_stb,
	input  wire                               dma_rd_stb,
	output sd_dma_pkg::fifo_stat_t            stat,
	output logic [sd_dma_pkg::data_w-1:0]     rd
);
	logic [sd_dma_pkg::ptr_w-1:0]  wptr;     // top bit = write done
	logic [sd_dma_pkg::ptr_w-1:0]  rptr;     // top bit = read done
	logic [sd_dma_pkg::data_w-1:0] mem [sd_dma_pkg::block_len];
	logic                          wr_stb;
	logic                          rd_stb;
	logic [sd_dma_pkg::data_w-1:0] wd;

	assign wr_stb = sd_wr.stb | dma_wr.stb;           // one side per direction
	assign rd_stb = sd_rd_stb | dma_rd_stb;
	assign wd     = sd_wr.stb ? sd_wr.data : dma_wr.data;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else if (init)
		begin
			wptr <= '0; // rearm for next block
			rptr <= '0;
		end
		else
		begin
			if (wr_stb)
				wptr <= wptr + 1'b1;
			if (rd_stb)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_stb)
			mem[wptr[sd_dma_pkg::ptr_w-2:0]] <= wd;
	end

	assign rd         = mem[rptr[sd_dma_pkg::ptr_w-2:0]]; // byte at read pointer
	assign stat.wdone = wptr[sd_dma_pkg::ptr_w-1];
	assign stat.rdone = rptr[sd_dma_pkg::ptr_w-1];
	assign stat.empty = (wptr == rptr);

	// pointer desync guards
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_stb |-> !stat.empty);
	a_no_wr_done:  assert property (@(posedge clk) disable iff (!rst_n) wr_stb |-> !stat.wdone);

endmodule

`default_nettype wire

//--- src/sd_dma_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dma_regs
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire sd_dma_pkg::reg_bus_t         bus,
	input  wire                               dma_ack,
	input  wire                               sd_busy,
	input  wire                               dma_busy,
	output logic [sd_dma_pkg::data_w-1:0]     dout,
	output logic [sd_dma_pkg::addr_w-1:0]     dma_addr,
	output logic                              dma_on,
	output logic                              snr,
	output logic                              start_pulse
);
	logic reg_wr; // cpu write this cycle
	logic go_wr;  // accepted control write
	logic finish; // both sides settled

	assign reg_wr = bus.sel && bus.wr;
	assign go_wr  = reg_wr && (bus.regsel == sd_dma_pkg::reg_cst) && !dma_on; // locked while running
	assign finish = dma_on && !start_pulse && !sd_busy && !dma_busy;

	////////////////////////////////////////////////////////////
	// readback

	always_comb
	begin
		dout = '0;
		case (bus.regsel)
			sd_dma_pkg::reg_had: dout = {2'b00, dma_addr[sd_dma_pkg::addr_w-1:16]};
			sd_dma_pkg::reg_mad: dout = dma_addr[15:8];
			sd_dma_pkg::reg_lad: dout = dma_addr[7:0];
			sd_dma_pkg::reg_cst:
			begin
				dout[sd_dma_pkg::cst_on_bit]  = dma_on;
				dout[sd_dma_pkg::cst_snr_bit] = snr; // burst bit stays 0
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// control and address

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dma_on      <= 1'b0;
			snr         <= 1'b0; // receive is the harmless default
			start_pulse <= 1'b0;
			dma_addr    <= '0;
		end
		else
		begin
			start_pulse <= go_wr && bus.din[sd_dma_pkg::cst_on_bit]; // one cycle kick
			if (go_wr)
			begin
				dma_on <= bus.din[sd_dma_pkg::cst_on_bit];
				snr    <= bus.din[sd_dma_pkg::cst_snr_bit];
			end
			else if (finish)
				dma_on <= 1'b0; // self clear

			if (dma_ack && dma_on)
				dma_addr <= dma_addr + 1'b1; // bump on every memory cycle
			else if (reg_wr && (bus.regsel == sd_dma_pkg::reg_had))
				dma_addr[sd_dma_pkg::addr_w-1:16] <= bus.din[sd_dma_pkg::addr_w-17:0];
			else if (reg_wr && (bus.regsel == sd_dma_pkg::reg_mad))
				dma_addr[15:8] <= bus.din;
			else if (reg_wr && (bus.regsel == sd_dma_pkg::reg_lad))
				dma_addr[7:0] <= bus.din;
		end
	end

	// a new start may only come out of an idle engine
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start_pulse |-> (!sd_busy && !dma_busy));

endmodule

`default_nettype wire

//--- src/sd_dma_pkg.sv
`default_nettype none

package sd_dma_pkg;

	////////////////////////////////////////////////////////////
	// sizes

	localparam int data_w    = 8;   // byte lane
	localparam int addr_w    = 22;  // dma address, 4M space
	localparam int block_len = 512; // one sd block per transfer
	localparam int ptr_w     = 10;  // fifo index plus done bit

	////////////////////////////////////////////////////////////
	// cpu side register map

	localparam logic [1:0] reg_had = 2'b00; // address bits 21..16
	localparam logic [1:0] reg_mad = 2'b01; // address bits 15..8
	localparam logic [1:0] reg_lad = 2'b10; // address bits 7..0
	localparam logic [1:0] reg_cst = 2'b11; // control and status

	localparam int cst_on_bit  = 7; // go / busy
	localparam int cst_snr_bit = 0; // 1 = send to card

	////////////////////////////////////////////////////////////
	// buses

	typedef struct packed
	{
		logic              sel;    // module selected
		logic              wr;     // write strobe
		logic [1:0]        regsel; // register code
		logic [data_w-1:0] din;    // write data
	} reg_bus_t;

	typedef struct packed
	{
		logic              start;      // one cycle exchange trigger
		logic              override;   // engine owns the spi
		logic [data_w-1:0] datatosend; // byte shifted out
	} spi_ctl_t;

	typedef struct packed
	{
		logic              stb;  // push strobe
		logic [data_w-1:0] data; // pushed byte
	} fifo_wr_t;

	typedef struct packed
	{
		logic wdone; // all bytes written
		logic rdone; // all bytes read back
		logic empty; // nothing to read right now
	} fifo_stat_t;

	typedef struct packed
	{
		logic              req; // level until ack
		logic              rnw; // 1 = memory read
		logic [data_w-1:0] wd;  // write data, valid at ack
	} dma_bus_t;

	typedef enum logic [1:0]
	{
		sd_idle     = 2'd0,
		sd_rx_start = 2'd1, // fire next read exchange
		sd_rx_wait  = 2'd2, // card shifting, byte lands on sd_rdy
		sd_tx_wait  = 2'd3  // fire when card ready and data present
	} sd_state_t;

	typedef enum logic [2:0]
	{
		dma_idle    = 3'd0,
		dma_put_req = 3'd1, // fifo -> memory, waiting ack
		dma_put_end = 3'd2,
		dma_get_req = 3'd3, // memory -> fifo, waiting ack
		dma_get_end = 3'd4
	} dma_state_t;

endpackage

`default_nettype wire
